//--- Makefile
# Verilator build and run for the pair-based branch predictor

VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bp_pkg.sv
`default_nettype none

package bp_pkg;

    ////////////////////////////////////////
    // branch type as stored in the tag table
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        brNone     = 2'd0,      // not a branch
        brCond     = 2'd1,      // conditional branch
        brUncond   = 2'd2,      // always taken
        brIndirect = 2'd3       // never stored
    } brType_t;

    ////////////////////////////////////////
    // 2-bit saturating counter
    ////////////////////////////////////////

    // msb set means predict taken
    typedef enum logic [1:0] {
        ctrStrongNot   = 2'd0,
        ctrWeakNot     = 2'd1,
        ctrWeakTaken   = 2'd2,
        ctrStrongTaken = 2'd3
    } ctrState_t;

endpackage

`default_nettype wire

//--- bp_settings.svh
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

////////////////////////////////////////
// predictor geometry
////////////////////////////////////////

`define BP_PC_WIDTH     32  // processor address width
`define BP_INDEX_WIDTH  5   // pair index, pc bits just above the pair offset
`define BP_TAG_WIDTH    24  // pc bits directly above the index
`define BP_ENTRY_WIDTH  10  // history + four 2-bit counters

// number of pairs held by each table
`define BP_PAIRS        (1 << `BP_INDEX_WIDTH)

// pc field positions
`define BP_SLOT_BIT     2
`define BP_INDEX_LSB    (`BP_SLOT_BIT + 1)
`define BP_TAG_LSB      (`BP_INDEX_LSB + `BP_INDEX_WIDTH)

`endif

//--- branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module branch_predictor (
    input  logic                     clk,
    input  logic                     rstn,
    // build, decode stage
    input  logic                     bdEn,
    input  logic [`BP_PC_WIDTH-1:0]  bdPC,
    input  bp_pkg::brType_t          bdTypeLower,
    input  bp_pkg::brType_t          bdTypeUpper,
    input  logic [`BP_PC_WIDTH-1:0]  bdTargetLower,
    input  logic [`BP_PC_WIDTH-1:0]  bdTargetUpper,
    input  logic                     bdBack,
    input  logic                     bdTaken,
    // update, execute stage
    input  logic                     upEn,
    input  logic [`BP_PC_WIDTH-1:0]  upPC,
    input  logic                     upTaken,
    // fetch lookup
    input  logic [`BP_PC_WIDTH-1:0]  ifPC,
    output logic                     ifHitLower,
    output logic                     ifHitUpper,
    output bp_pkg::brType_t          ifTypeLower,
    output bp_pkg::brType_t          ifTypeUpper,
    output logic [`BP_PC_WIDTH-1:0]  ifTargetLower,
    output logic [`BP_PC_WIDTH-1:0]  ifTargetUpper,
    output logic                     ifTakenLower,
    output logic                     ifTakenUpper
);
    import bp_pkg::*;

    logic      eraseLower, eraseUpper;  // history invalidate on accepted build
    logic      upWrite;                 // update permitted by a tag hit
    brType_t   upType;

    tag_table tagTable (
        .clk(clk), .rstn(rstn),
        .bdEn(bdEn), .bdPC(bdPC),
        .bdTypeLower(bdTypeLower), .bdTypeUpper(bdTypeUpper),
        .bdTargetLower(bdTargetLower), .bdTargetUpper(bdTargetUpper),
        .upEn(upEn), .upPC(upPC), .ifPC(ifPC),
        .eraseLower(eraseLower), .eraseUpper(eraseUpper),
        .upWrite(upWrite), .upType(upType),
        .ifHitLower(ifHitLower), .ifHitUpper(ifHitUpper),
        .ifTypeLower(ifTypeLower), .ifTypeUpper(ifTypeUpper),
        .ifTargetLower(ifTargetLower), .ifTargetUpper(ifTargetUpper)
    );

    history_table historyTable (
        .clk(clk), .rstn(rstn),
        .eraseLower(eraseLower), .eraseUpper(eraseUpper),
        .bdPC(bdPC), .bdBack(bdBack),
        .upWrite(upWrite), .upType(upType),
        .upPC(upPC), .upTaken(upTaken),
        .ifPC(ifPC),
        .ifTakenLower(ifTakenLower), .ifTakenUpper(ifTakenUpper)
    );

endmodule

`default_nettype wire

//--- history_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module history_table (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     eraseLower,
    input  logic                     eraseUpper,
    input  logic [`BP_PC_WIDTH-1:0]  bdPC,
    input  logic                     bdBack,
    input  logic                     upWrite,
    input  bp_pkg::brType_t          upType,
    input  logic [`BP_PC_WIDTH-1:0]  upPC,
    input  logic                     upTaken,
    input  logic [`BP_PC_WIDTH-1:0]  ifPC,
    output logic                     ifTakenLower,
    output logic                     ifTakenUpper
);
    import bp_pkg::*;

    localparam int EW = `BP_ENTRY_WIDTH;

    logic [`BP_INDEX_WIDTH-1:0] bdIndex, upIndex, ifIndex;
    logic                       upSlot;
    logic [2*`BP_PAIRS-1:0]     histValid;  // indexed by {pair index, slot}
    logic [1:0][2*EW-1:0]       pairRd;     // 0 update, 1 fetch
    logic [EW-1:0]              oldEntry, newEntry;
    logic [2*EW-1:0]            pairWr;
    logic                       upValid;

    // taken when the counter selected by the history has its msb set
    function automatic logic predictTaken(input logic [EW-1:0] e);
        ctrState_t ctr;
        ctr = ctrState_t'(e[{e[EW-1 -: 2], 1'b0} +: 2]);
        return (ctr == ctrWeakTaken) || (ctr == ctrStrongTaken);
    endfunction

    assign bdIndex = bdPC[`BP_INDEX_LSB +: `BP_INDEX_WIDTH];
    assign upIndex = upPC[`BP_INDEX_LSB +: `BP_INDEX_WIDTH];
    assign ifIndex = ifPC[`BP_INDEX_LSB +: `BP_INDEX_WIDTH];
    assign upSlot  = upPC[`BP_SLOT_BIT];

    ////////////////////////////////////////
    // update path
    ////////////////////////////////////////

    assign upValid  = histValid[{upIndex, upSlot}];
    assign oldEntry = upSlot ? pairRd[0][2*EW-1:EW] : pairRd[0][EW-1:0];

    pattern_update patternUpdate (
        .init(~upValid), .slotType(upType), .back(bdBack),
        .taken(upTaken), .old(oldEntry), .entry(newEntry)
    );

    // keep the other slot's entry in the pair word
    assign pairWr = upSlot ? {newEntry, pairRd[0][EW-1:0]}
                           : {pairRd[0][2*EW-1:EW], newEntry};

    slot_memory #(.dataWidth(2*EW), .readPorts(2)) patternMem (
        .clk(clk), .wrEn(upWrite), .wrAddr(upIndex), .wrData(pairWr),
        .rdAddr({ifIndex, upIndex}), .rdData(pairRd)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            histValid <= '0;
        end else begin
            if (upWrite) histValid[{upIndex, upSlot}] <= 1'b1;
            // erase of a rebuilt pair wins over a same-cycle update
            if (eraseLower) histValid[{bdIndex, 1'b0}] <= 1'b0;
            if (eraseUpper) histValid[{bdIndex, 1'b1}] <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // fetch prediction
    ////////////////////////////////////////

    assign ifTakenLower = histValid[{ifIndex, 1'b0}] & predictTaken(pairRd[1][EW-1:0]);
    assign ifTakenUpper = histValid[{ifIndex, 1'b1}] & predictTaken(pairRd[1][2*EW-1:EW]);

    // entries only come to life through a permitted update
    assert property (@(posedge clk) disable iff (!rstn)
        (histValid & ~$past(histValid)) != '0 |-> $past(upWrite));

endmodule

`default_nettype wire

//--- pattern_update.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

// initial or trained pattern entry for one slot
module pattern_update (
    input  logic                        init,      // entry not yet valid
    input  bp_pkg::brType_t             slotType,
    input  logic                        back,      // backward branch
    input  logic                        taken,     // resolved outcome
    input  logic [`BP_ENTRY_WIDTH-1:0]  old,
    output logic [`BP_ENTRY_WIDTH-1:0]  entry
);
    import bp_pkg::*;

    logic [1:0] hist;
    ctrState_t  ctrOld, ctrNew;
    logic [`BP_ENTRY_WIDTH-1:0] initEntry, trainEntry;

    assign hist = old[`BP_ENTRY_WIDTH-1 -: 2];

    ////////////////////////////////////////
    // first entry for a fresh slot
    ////////////////////////////////////////

    always_comb begin
        case (slotType)
            brUncond: initEntry = '1;           // always taken
            brCond: begin
                if (back) begin
                    initEntry = {back, taken, ctrWeakTaken, ctrWeakTaken,
                                 ctrWeakTaken, ctrWeakNot};
                end else begin
                    initEntry = {back, taken, ctrWeakTaken, ctrWeakNot,
                                 ctrWeakNot, ctrWeakNot};
                end
            end
            default: initEntry = '0;
        endcase
    end

    ////////////////////////////////////////
    // training
    ////////////////////////////////////////

    always_comb begin
        ctrOld = ctrState_t'(old[{hist, 1'b0} +: 2]);  // counter picked by history
        case (ctrOld)
            ctrStrongNot:   ctrNew = taken ? ctrWeakNot     : ctrStrongNot;
            ctrWeakNot:     ctrNew = taken ? ctrWeakTaken   : ctrStrongNot;
            ctrWeakTaken:   ctrNew = taken ? ctrStrongTaken : ctrWeakNot;
            ctrStrongTaken: ctrNew = taken ? ctrStrongTaken : ctrWeakTaken;
            default:        ctrNew = ctrOld;
        endcase

        trainEntry = old;
        trainEntry[{hist, 1'b0} +: 2] = ctrNew;
        trainEntry[`BP_ENTRY_WIDTH-1 -: 2] = {hist[0], taken};  // shift in outcome
    end

    assign entry = init ? initEntry : trainEntry;

endmodule

`default_nettype wire

//--- project.f
+incdir+.
bp_pkg.sv
slot_memory.sv
pattern_update.sv
tag_table.sv
history_table.sv
branch_predictor.sv
tb_branch_predictor.sv

//--- slot_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

// one word per pair index, written on the clock edge and read
// combinationally on every port
module slot_memory #(
    parameter int dataWidth = 32,
    parameter int readPorts = 1
) (
    input  logic                                       clk,
    input  logic                                       wrEn,
    input  logic [`BP_INDEX_WIDTH-1:0]                 wrAddr,
    input  logic [dataWidth-1:0]                       wrData,
    input  logic [readPorts-1:0][`BP_INDEX_WIDTH-1:0]  rdAddr,
    output logic [readPorts-1:0][dataWidth-1:0]        rdData
);

    logic [dataWidth-1:0] mem [`BP_PAIRS];  // contents qualified by owner's valid bits

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // async read ports
    genvar p;
    generate
        for (p = 0; p < readPorts; p++) begin : gRead
            assign rdData[p] = mem[rdAddr[p]];
        end
    endgenerate

endmodule

`default_nettype wire

//--- tag_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module tag_table (
    input  logic                     clk,
    input  logic                     rstn,
    // build port, decode stage
    input  logic                     bdEn,
    input  logic [`BP_PC_WIDTH-1:0]  bdPC,
    input  bp_pkg::brType_t          bdTypeLower,
    input  bp_pkg::brType_t          bdTypeUpper,
    input  logic [`BP_PC_WIDTH-1:0]  bdTargetLower,
    input  logic [`BP_PC_WIDTH-1:0]  bdTargetUpper,
    // update port, execute stage
    input  logic                     upEn,
    input  logic [`BP_PC_WIDTH-1:0]  upPC,
    // fetch lookup
    input  logic [`BP_PC_WIDTH-1:0]  ifPC,
    // strobes to the history table
    output logic                     eraseLower,
    output logic                     eraseUpper,
    output logic                     upWrite,
    output bp_pkg::brType_t          upType,
    output logic                     ifHitLower,
    output logic                     ifHitUpper,
    output bp_pkg::brType_t          ifTypeLower,
    output bp_pkg::brType_t          ifTypeUpper,
    output logic [`BP_PC_WIDTH-1:0]  ifTargetLower,
    output logic [`BP_PC_WIDTH-1:0]  ifTargetUpper
);
    import bp_pkg::*;

    logic [`BP_INDEX_WIDTH-1:0] bdIndex, upIndex, ifIndex;
    logic [`BP_TAG_WIDTH-1:0]   bdTag, upTag, ifTag;
    logic [`BP_PAIRS-1:0]       validLower, validUpper;
    logic [2:0][`BP_TAG_WIDTH-1:0] tagLowerRd, tagUpperRd;   // 0 build, 1 update, 2 fetch
    logic [1:0][`BP_PC_WIDTH-1:0]  wordLowerRd, wordUpperRd; // 0 update, 1 fetch
    logic bdUsefulLower, bdUsefulUpper;
    logic bdExist, bdAccept;
    logic upHitLower, upHitUpper;

    assign bdIndex = bdPC[`BP_INDEX_LSB +: `BP_INDEX_WIDTH];
    assign upIndex = upPC[`BP_INDEX_LSB +: `BP_INDEX_WIDTH];
    assign ifIndex = ifPC[`BP_INDEX_LSB +: `BP_INDEX_WIDTH];
    assign bdTag   = bdPC[`BP_TAG_LSB +: `BP_TAG_WIDTH];
    assign upTag   = upPC[`BP_TAG_LSB +: `BP_TAG_WIDTH];
    assign ifTag   = ifPC[`BP_TAG_LSB +: `BP_TAG_WIDTH];

    ////////////////////////////////////////
    // build acceptance
    ////////////////////////////////////////

    assign bdUsefulLower = (bdTypeLower == brCond) || (bdTypeLower == brUncond);
    assign bdUsefulUpper = (bdTypeUpper == brCond) || (bdTypeUpper == brUncond);

    // pair already present on a slot the build would write
    assign bdExist = (bdUsefulLower & validLower[bdIndex] & (tagLowerRd[0] == bdTag))
                   | (bdUsefulUpper & validUpper[bdIndex] & (tagUpperRd[0] == bdTag));
    assign bdAccept = bdEn & ~bdExist;

    assign eraseLower = bdAccept & bdUsefulLower;  // also the slot write enable
    assign eraseUpper = bdAccept & bdUsefulUpper;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            validLower <= '0;
            validUpper <= '0;
        end else begin
            if (eraseLower) validLower[bdIndex] <= 1'b1;
            if (eraseUpper) validUpper[bdIndex] <= 1'b1;
        end
    end

    slot_memory #(.dataWidth(`BP_TAG_WIDTH), .readPorts(3)) tagLowerMem (
        .clk(clk), .wrEn(eraseLower), .wrAddr(bdIndex), .wrData(bdTag),
        .rdAddr({ifIndex, upIndex, bdIndex}), .rdData(tagLowerRd)
    );

    slot_memory #(.dataWidth(`BP_TAG_WIDTH), .readPorts(3)) tagUpperMem (
        .clk(clk), .wrEn(eraseUpper), .wrAddr(bdIndex), .wrData(bdTag),
        .rdAddr({ifIndex, upIndex, bdIndex}), .rdData(tagUpperRd)
    );

    // target word carries the type in bits 1:0
    slot_memory #(.dataWidth(`BP_PC_WIDTH), .readPorts(2)) wordLowerMem (
        .clk(clk), .wrEn(eraseLower), .wrAddr(bdIndex),
        .wrData({bdTargetLower[`BP_PC_WIDTH-1:2], bdTypeLower}),
        .rdAddr({ifIndex, upIndex}), .rdData(wordLowerRd)
    );

    slot_memory #(.dataWidth(`BP_PC_WIDTH), .readPorts(2)) wordUpperMem (
        .clk(clk), .wrEn(eraseUpper), .wrAddr(bdIndex),
        .wrData({bdTargetUpper[`BP_PC_WIDTH-1:2], bdTypeUpper}),
        .rdAddr({ifIndex, upIndex}), .rdData(wordUpperRd)
    );

    ////////////////////////////////////////
    // update permit and lookup
    ////////////////////////////////////////

    assign upHitLower = validLower[upIndex] & (tagLowerRd[1] == upTag);
    assign upHitUpper = validUpper[upIndex] & (tagUpperRd[1] == upTag);
    assign upWrite = upEn & (upPC[`BP_SLOT_BIT] ? upHitUpper : upHitLower);
    assign upType  = brType_t'(upPC[`BP_SLOT_BIT] ? wordUpperRd[0][1:0] : wordLowerRd[0][1:0]);

    assign ifHitLower = validLower[ifIndex] & (tagLowerRd[2] == ifTag);
    assign ifHitUpper = validUpper[ifIndex] & (tagUpperRd[2] == ifTag);
    assign ifTypeLower = ifHitLower ? brType_t'(wordLowerRd[1][1:0]) : brNone;
    assign ifTypeUpper = ifHitUpper ? brType_t'(wordUpperRd[1][1:0]) : brNone;
    assign ifTargetLower = ifHitLower ? {wordLowerRd[1][`BP_PC_WIDTH-1:2], 2'b00} : '0;
    assign ifTargetUpper = ifHitUpper ? {wordUpperRd[1][`BP_PC_WIDTH-1:2], 2'b00} : '0;

    // an erase comes from a real build of a useful slot, which is then valid
    assert property (@(posedge clk) disable iff (!rstn)
        eraseLower |=> $past(bdEn) && $past(bdUsefulLower) && validLower[$past(bdIndex)]);
    assert property (@(posedge clk) disable iff (!rstn)
        eraseUpper |=> $past(bdEn) && $past(bdUsefulUpper) && validUpper[$past(bdIndex)]);

endmodule

`default_nettype wire

//--- tb_branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int CLK_PERIOD = 8;

    typedef enum logic [1:0] {opIdle, opBuild, opUpdate, opLookup} opCode_t;

    typedef struct packed {
        opCode_t                 op;
        logic [`BP_PC_WIDTH-1:0] pc;
        brType_t                 typeLo, typeHi;   // build types, or expected types
        logic [`BP_PC_WIDTH-1:0] tgtLo, tgtHi;     // build targets, or expected targets
        logic                    back, taken;
        logic                    hitLo, hitHi, takenLo, takenHi;  // expected on lookup
    } stimRow_t;

    logic                    clk, rstn;
    logic                    bdEn, bdBack, bdTaken, upEn, upTaken;
    logic [`BP_PC_WIDTH-1:0] bdPC, bdTargetLower, bdTargetUpper, upPC, ifPC;
    brType_t                 bdTypeLower, bdTypeUpper, ifTypeLower, ifTypeUpper;
    logic                    ifHitLower, ifHitUpper, ifTakenLower, ifTakenUpper;
    logic [`BP_PC_WIDTH-1:0] ifTargetLower, ifTargetUpper;

    stimRow_t rows[$];
    logic [15:0] lfsr;

    branch_predictor branch_predictor_i (
        .clk(clk), .rstn(rstn),
        .bdEn(bdEn), .bdPC(bdPC), .bdTypeLower(bdTypeLower), .bdTypeUpper(bdTypeUpper),
        .bdTargetLower(bdTargetLower), .bdTargetUpper(bdTargetUpper),
        .bdBack(bdBack), .bdTaken(bdTaken),
        .upEn(upEn), .upPC(upPC), .upTaken(upTaken), .ifPC(ifPC),
        .ifHitLower(ifHitLower), .ifHitUpper(ifHitUpper),
        .ifTypeLower(ifTypeLower), .ifTypeUpper(ifTypeUpper),
        .ifTargetLower(ifTargetLower), .ifTargetUpper(ifTargetUpper),
        .ifTakenLower(ifTakenLower), .ifTakenUpper(ifTakenUpper)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsrBit = lfsr[15];
        lfsr = {lfsr[14:0], fb};
    endfunction

    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsrBit()};  // one step per bit
        end
        return v;
    endfunction

    function automatic logic [`BP_PC_WIDTH-1:0] pairPC(input logic [23:0] tag,
                                                       input logic [4:0] index);
        return {tag, index, 3'b000};
    endfunction

    // lookup returns the target with the type bits cleared
    function automatic logic [`BP_PC_WIDTH-1:0] cleanTarget(input logic [`BP_PC_WIDTH-1:0] t);
        return {t[`BP_PC_WIDTH-1:2], 2'b00};
    endfunction

    task automatic buildRow(input logic [31:0] pc, input brType_t tLo, input brType_t tHi,
                            input logic [31:0] gLo, input logic [31:0] gHi,
                            input logic back);
        stimRow_t r;
        r = '0;
        r.op = opBuild;
        r.pc = pc;
        r.typeLo = tLo;
        r.typeHi = tHi;
        r.tgtLo = gLo;
        r.tgtHi = gHi;
        r.back = back;
        rows.push_back(r);
    endtask

    task automatic updateRow(input logic [31:0] pc, input logic taken, input logic back);
        stimRow_t r;
        r = '0;
        r.op = opUpdate;
        r.pc = pc;
        r.taken = taken;
        r.back = back;  // direction used when the entry is initialized
        rows.push_back(r);
    endtask

    task automatic lookupRow(input logic [31:0] pc, input logic hLo, input logic hHi,
                             input brType_t tLo, input brType_t tHi,
                             input logic [31:0] gLo, input logic [31:0] gHi,
                             input logic kLo, input logic kHi);
        stimRow_t r;
        r = '0;
        r.op = opLookup;
        r.pc = pc;
        r.hitLo = hLo;
        r.hitHi = hHi;
        r.typeLo = tLo;
        r.typeHi = tHi;
        r.tgtLo = gLo;
        r.tgtHi = gHi;
        r.takenLo = kLo;
        r.takenHi = kHi;
        rows.push_back(r);
    endtask

    task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
        if (got !== expected) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("Test failures found");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic waitFall();
        int edges;
        edges = 0;
        do begin
            @(clk);
            edges++;
            if (edges > 4) begin
                $display("The clock stopped toggling before the next falling edge.");
                $display("Test failures found");
                $fatal(1, "clock stalled");
            end
        end while (clk !== 1'b0);
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    task automatic fillTable();
        logic [31:0] pcA, pcB, pcMiss, pcAlias, tgtA0, tgtA1, tgtB1, aliasLo, aliasHi;
        logic [31:0] tagBits;
        pcA = pairPC(24'h000123, 5'd1);
        pcB = pairPC(24'h000456, 5'd2);
        pcMiss = pairPC(24'h000777, 5'd1);  // same index as pcA
        tgtA0 = 32'h0000_1003;              // low bits get replaced by the type
        tgtA1 = 32'h0000_2004;
        tgtB1 = 32'h0000_3008;
        tagBits = randomBits(24);
        if (tagBits[23:0] == 24'h000123) tagBits[0] = ~tagBits[0];
        pcAlias = pairPC(tagBits[23:0], 5'd1);
        aliasLo = randomBits(32);
        aliasHi = randomBits(32);

        lookupRow(pcA, 0, 0, brNone, brNone, 0, 0, 0, 0);  // empty after reset
        lookupRow(pcB, 0, 0, brNone, brNone, 0, 0, 0, 0);
        lookupRow(32'h0, 0, 0, brNone, brNone, 0, 0, 0, 0);
        buildRow(pcA, brCond, brUncond, tgtA0, tgtA1, 1'b1);
        lookupRow(pcA, 1, 1, brCond, brUncond, cleanTarget(tgtA0), cleanTarget(tgtA1), 0, 0);
        buildRow(pcB, brNone, brCond, 32'hDEAD_BEEF, tgtB1, 1'b0);
        lookupRow(pcB, 0, 1, brNone, brCond, 0, cleanTarget(tgtB1), 0, 0);
        buildRow(pcA, brCond, brUncond, 32'h0000_5000, 32'h0000_6000, 1'b0);  // pair exists
        lookupRow(pcA, 1, 1, brCond, brUncond, cleanTarget(tgtA0), cleanTarget(tgtA1), 0, 0);

        // backward cond init: hist 3, counters WT WT WT WN
        updateRow(pcA, 1'b1, 1'b1);
        lookupRow(pcA, 1, 1, brCond, brUncond, cleanTarget(tgtA0), cleanTarget(tgtA1), 1, 0);
        updateRow(pcA, 1'b0, 1'b0);  // c3 -> WN, hist 2, c2 WT
        lookupRow(pcA, 1, 1, brCond, brUncond, cleanTarget(tgtA0), cleanTarget(tgtA1), 1, 0);
        updateRow(pcA, 1'b0, 1'b0);  // c2 -> WN, hist 0, c0 WN
        lookupRow(pcA, 1, 1, brCond, brUncond, cleanTarget(tgtA0), cleanTarget(tgtA1), 0, 0);
        updateRow(pcA, 1'b0, 1'b0);  // c0 -> SN, hist 0
        lookupRow(pcA, 1, 1, brCond, brUncond, cleanTarget(tgtA0), cleanTarget(tgtA1), 0, 0);
        updateRow(pcA, 1'b1, 1'b0);  // c0 -> WN, hist 1, c1 WT
        lookupRow(pcA, 1, 1, brCond, brUncond, cleanTarget(tgtA0), cleanTarget(tgtA1), 1, 0);
        updateRow(pcA | 32'h4, 1'b0, 1'b0);  // uncond init is all ones
        lookupRow(pcA, 1, 1, brCond, brUncond, cleanTarget(tgtA0), cleanTarget(tgtA1), 1, 1);

        // a tag miss must not train c1 down
        updateRow(pcMiss, 1'b0, 1'b0);
        lookupRow(pcA, 1, 1, brCond, brUncond, cleanTarget(tgtA0), cleanTarget(tgtA1), 1, 1);
        rows.push_back('0);

        // rebuild at index 1 with a random tag erases both histories
        buildRow(pcAlias, brCond, brCond, aliasLo, aliasHi, 1'b0);
        lookupRow(pcAlias, 1, 1, brCond, brCond, cleanTarget(aliasLo), cleanTarget(aliasHi),
                  0, 0);
        lookupRow(pcA, 0, 0, brNone, brNone, 0, 0, 0, 0);
        updateRow(pcAlias, 1'b1, 1'b1);
        lookupRow(pcAlias, 1, 1, brCond, brCond, cleanTarget(aliasLo), cleanTarget(aliasHi),
                  1, 0);
        updateRow(pcAlias | 32'h4, 1'b0, 1'b0);  // forward init, hist 0 picks c0 WN
        lookupRow(pcAlias, 1, 1, brCond, brCond, cleanTarget(aliasLo), cleanTarget(aliasHi),
                  1, 0);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        stimRow_t r;
        rstn = 1'b0;
        bdEn = 1'b0;
        bdPC = '0;
        bdTypeLower = brNone;
        bdTypeUpper = brNone;
        bdTargetLower = '0;
        bdTargetUpper = '0;
        bdBack = 1'b0;
        bdTaken = 1'b0;
        upEn = 1'b0;
        upPC = '0;
        upTaken = 1'b0;
        ifPC = '0;
        lfsr = 16'd44;
        fillTable();

        for (int c = 0; c < 4; c++) begin
            waitFall();
        end
        rstn = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            waitFall();
            bdEn = (r.op == opBuild);
            bdPC = r.pc;
            bdTypeLower = r.typeLo;
            bdTypeUpper = r.typeHi;
            bdTargetLower = r.tgtLo;
            bdTargetUpper = r.tgtHi;
            bdBack = r.back;
            bdTaken = r.taken;
            upEn = (r.op == opUpdate);
            upPC = r.pc;
            upTaken = r.taken;
            ifPC = (r.op == opLookup) ? r.pc : '0;
            if (r.op == opLookup) begin
                #(CLK_PERIOD/2 - 1);  // just before the rising edge
                checkValue(32'(ifHitLower), 32'(r.hitLo), $sformatf("row %0d hit lower", i));
                checkValue(32'(ifHitUpper), 32'(r.hitHi), $sformatf("row %0d hit upper", i));
                checkValue(32'(ifTypeLower), 32'(r.typeLo), $sformatf("row %0d type lower", i));
                checkValue(32'(ifTypeUpper), 32'(r.typeHi), $sformatf("row %0d type upper", i));
                checkValue(ifTargetLower, r.tgtLo, $sformatf("row %0d target lower", i));
                checkValue(ifTargetUpper, r.tgtHi, $sformatf("row %0d target upper", i));
                checkValue(32'(ifTakenLower), 32'(r.takenLo), $sformatf("row %0d taken lower", i));
                checkValue(32'(ifTakenUpper), 32'(r.takenHi), $sformatf("row %0d taken upper", i));
            end
        end

        waitFall();
        bdEn = 1'b0;
        upEn = 1'b0;
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
